/* bench/timers_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module timers_asserts
    import ss_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input ss_addr_t ss_bus_addr,
    input ss_word_t ss_bus_in,
    input logic     ss_bus_wren,
    input logic     ss_bus_reset_n,
    input ss_word_t ss_bus_out,
    input logic     irq
);

    logic write_seen;
    int   failures = 0;

    // A restore that actually lands in a block
    assign write_seen = rst_n && ss_bus_reset_n && ss_bus_wren
                     && (ss_bus_addr >= SS_ADDR_CLOCK) && (ss_bus_addr <= SS_ADDR_INPUT);

    unused_addr_reads_zero: assert property (@(posedge clk)
        rst_n && (ss_bus_addr < SS_ADDR_CLOCK || ss_bus_addr > SS_ADDR_INPUT)
        |=> ss_bus_out == '0)
        else begin
            failures++;
            $error("ss_bus_out not zero after an unused address");
        end

    irq_low_after_clear: assert property (@(posedge clk)
        (!rst_n || !ss_bus_reset_n) |=> !irq)
        else begin
            failures++;
            $error("irq high with all factors cleared");
        end

    // Same address held for the read cycle after the write
    write_readback: assert property (@(posedge clk)
        $past(write_seen) && rst_n && (ss_bus_addr == $past(ss_bus_addr))
        |=> ss_bus_out == $past(ss_bus_in, 2))
        else begin
            failures++;
            $error("savestate readback differs from the word written");
        end

endmodule

`default_nettype wire

/* bench/timers_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module timers_tb
    import ss_pkg::*;
();

    // Copy of every block's savestate fields
    typedef struct packed {
        logic [6:0] divider;
        logic [7:0] cnt256;
        logic       tick;
        logic [3:0] c100;
        logic [3:0] swl;
        logic [3:0] swh;
        logic [1:0] sw_ff;
        logic       div8k;
        logic [5:0] cnt8k;
        logic [7:0] down;
        logic       pf;
        logic [3:0] prev_tb;
        logic [3:0] clk_ff;
        logic [1:0] prev_k;
        logic [1:0] in_ff;
    } model_t;

    logic       clk;
    logic       rst_n;
    logic       clk_en;
    logic       sw_run;
    logic       prog_run;
    logic       factor_ack;
    logic [7:0] prog_reload;
    logic [1:0] k_in;
    ss_addr_t   ss_bus_addr;
    ss_word_t   ss_bus_in;
    logic       ss_bus_wren;
    logic       ss_bus_reset_n;
    ss_word_t   ss_bus_out;
    logic       irq;

    model_t   model;
    ss_word_t exp_out;
    logic     exp_irq;
    logic     model_live = 1'b0;
    int       errors = 0;

    timers_top dut (.*);

    bind timers_top timers_asserts asserts (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic model_t step_model(model_t s, logic clear, logic en, logic sw_on,
            logic prog_on, logic ack, logic [7:0] reload, logic [1:0] keys,
            ss_addr_t a, ss_word_t d, logic we);
        model_t      n;
        timer_bits_t now_tb;
        logic [1:0]  sw_set;
        logic        pf_set;
        n      = s;
        sw_set = 2'b00;
        pf_set = 1'b0;
        now_tb = '{timer_32hz: s.cnt256[2], timer_8hz: s.cnt256[4],
                   timer_2hz: s.cnt256[6], timer_1hz: s.cnt256[7]};
        if (clear) begin
            return '0;
        end
        if (we && a == SS_ADDR_CLOCK) begin
            {n.tick, n.divider, n.cnt256} = d[15:0];
        end else begin
            n.tick = en && (s.divider == 7'd127);   // Divider wrap
            if (en) n.divider = s.divider + 7'd1;
            if (n.tick) n.cnt256 = s.cnt256 + 8'd1;
        end
        if (we && a == SS_ADDR_STOPWATCH) begin
            {n.sw_ff, n.c100, n.swh, n.swl} = d[13:0];
        end else begin
            if (s.tick && sw_on) begin
                n.c100 = s.c100 + 4'd1;
                if (s.c100 >= 4'd9) begin
                    n.c100 = 4'd0;
                    n.swl  = s.swl + 4'd1;
                    if (s.swl >= 4'd9) begin   // Low digit rollover
                        n.swl     = 4'd0;
                        n.swh     = s.swh + 4'd1;
                        sw_set[0] = 1'b1;
                        if (s.swh >= 4'd9) begin
                            n.swh     = 4'd0;
                            sw_set[1] = 1'b1;
                        end
                    end
                end
            end
            n.sw_ff = (ack ? 2'b00 : s.sw_ff) | sw_set;
        end
        if (we && a == SS_ADDR_PROG) begin
            {n.pf, n.down, n.div8k, n.cnt8k} = d[15:0];
        end else begin
            if (en && prog_on) begin
                n.div8k = !s.div8k;
                if (s.div8k) begin
                    n.cnt8k = s.cnt8k + 6'd1;
                    if (s.cnt8k == 6'd63) begin
                        if (s.down == 8'd1) begin
                            n.down = reload;
                            pf_set = 1'b1;
                        end else if (s.down == 8'd0) begin
                            n.down = reload;    // Restored zero, no factor
                        end else begin
                            n.down = s.down - 8'd1;
                        end
                    end
                end
            end
            n.pf = pf_set || (s.pf && !ack);
        end
        if (we && a == SS_ADDR_INTERRUPT) begin
            {n.prev_tb, n.clk_ff} = d[7:0];
        end else begin
            n.prev_tb = now_tb;
            n.clk_ff  = (ack ? 4'b0000 : s.clk_ff) | (s.prev_tb & ~now_tb);
        end
        n.prev_k = keys;
        if (we && a == SS_ADDR_INPUT) begin
            n.in_ff = d[1:0];
        end else begin
            n.in_ff = (ack ? 2'b00 : s.in_ff) | (s.prev_k & ~keys);
        end
        return n;
    endfunction

    function automatic ss_word_t word_of(model_t s, ss_addr_t a);
        case (a)
            SS_ADDR_CLOCK:     return {16'b0, s.tick, s.divider, s.cnt256};
            SS_ADDR_STOPWATCH: return {18'b0, s.sw_ff, s.c100, s.swh, s.swl};
            SS_ADDR_PROG:      return {16'b0, s.pf, s.down, s.div8k, s.cnt8k};
            SS_ADDR_INTERRUPT: return {24'b0, s.prev_tb, s.clk_ff};
            SS_ADDR_INPUT:     return {30'b0, s.in_ff};
            default:           return '0;
        endcase
    endfunction

    function automatic logic irq_of(model_t s);
        return |{s.clk_ff, s.in_ff, s.sw_ff, s.pf};
    endfunction

    // Used bits of each savestate word
    function automatic ss_word_t layout_mask(ss_addr_t a);
        case (a)
            SS_ADDR_STOPWATCH: return 32'h0000_3fff;
            SS_ADDR_INTERRUPT: return 32'h0000_00ff;
            SS_ADDR_INPUT:     return 32'h0000_0003;
            default:           return 32'h0000_ffff;
        endcase
    endfunction

    task automatic stop_run();
        errors++;
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input ss_word_t exp, input ss_word_t got);
        if (got !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, got);
            stop_run();
        end
    endtask

    // Model steps on the same edge the DUT samples
    always @(posedge clk) begin
        exp_out = rst_n ? word_of(model, ss_bus_addr) : '0;
        model   = step_model(model, !rst_n || !ss_bus_reset_n, clk_en, sw_run, prog_run,
                             factor_ack, prog_reload, k_in, ss_bus_addr, ss_bus_in,
                             ss_bus_wren);
        exp_irq    = irq_of(model);
        model_live = 1'b1;
    end

    always @(negedge clk) begin
        if (model_live) begin
            check_word("ss_bus_out", exp_out, ss_bus_out);
            check_bit("irq", exp_irq, irq);
        end
        if (dut.asserts.failures != 0) begin
            $display("A savestate or interrupt assertion failed");
            stop_run();
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_cycles(input int count, input logic rand_en);
        for (int i = 0; i < count; i++) begin
            if (rand_en) clk_en = ($urandom % 4) != 0;
            next_cycle();
        end
    endtask

    task automatic savestate_reset();
        ss_bus_reset_n = 1'b0;
        run_cycles(2, 1'b0);
        ss_bus_reset_n = 1'b1;
    endtask

    task automatic write_and_read(input ss_addr_t a, input ss_word_t d);
        ss_bus_addr = a;
        ss_bus_in   = d;
        ss_bus_wren = 1'b1;
        next_cycle();
        ss_bus_wren = 1'b0;
        next_cycle();
        check_word("ss_bus_out", d, ss_bus_out);
    endtask

    task automatic wait_word_bit(input ss_addr_t a, input int bit_pos, input int limit,
                                 input logic rand_en);
        logic seen;
        seen        = 1'b0;
        ss_bus_addr = a;
        for (int i = 0; i < limit && !seen; i++) begin
            if (rand_en) clk_en = ($urandom % 4) != 0;
            next_cycle();
            seen = (ss_bus_out[bit_pos] === 1'b1);
        end
        if (!seen) begin
            $display("Timeout: bit %0d at address %0d not set after %0d cycles",
                     bit_pos, a, limit);
            stop_run();
        end
    endtask

    task automatic wait_irq(input logic level, input int limit);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            next_cycle();
            seen = (irq === level);
        end
        if (!seen) begin
            $display("Timeout: irq did not reach %b within %0d cycles", level, limit);
            stop_run();
        end
    endtask

    initial begin
        void'($urandom(32'haad53497));
        rst_n          = 1'b0;
        clk_en         = 1'b0;
        sw_run         = 1'b0;
        prog_run       = 1'b0;
        factor_ack     = 1'b0;
        prog_reload    = 8'd0;
        k_in           = 2'b00;
        ss_bus_addr    = '0;
        ss_bus_in      = '0;
        ss_bus_wren    = 1'b0;
        ss_bus_reset_n = 1'b1;
        run_cycles(16, 1'b0);
        rst_n = 1'b1;

        // Counting and full restores before the savestate reset clears every word
        ss_bus_addr = SS_ADDR_CLOCK;
        clk_en      = 1'b1;
        run_cycles(300, 1'b0);
        clk_en = 1'b0;
        for (int a = 3; a <= 6; a++) begin
            write_and_read(ss_addr_t'(a), layout_mask(ss_addr_t'(a)));
        end
        ss_bus_reset_n = 1'b0;
        run_cycles(2, 1'b0);
        for (int a = 0; a < 8; a++) begin
            ss_bus_addr = ss_addr_t'(a);
            next_cycle();
            check_word("ss_bus_out", '0, ss_bus_out);
        end
        ss_bus_reset_n = 1'b1;

        // Random restores, everything idle
        for (int round = 0; round < 4; round++) begin
            for (int a = 2; a <= 6; a++) begin
                write_and_read(ss_addr_t'(a), $urandom & layout_mask(ss_addr_t'(a)));
            end
        end
        savestate_reset();

        // Divider 120, counter 0xfe so the counter wraps as well
        write_and_read(SS_ADDR_CLOCK, 32'h0000_78fe);
        wait_word_bit(SS_ADDR_CLOCK, 15, 64, 1'b1);
        run_cycles(600, 1'b1);
        clk_en = 1'b0;
        savestate_reset();

        prog_reload = 8'd3;
        write_and_read(SS_ADDR_CLOCK, 32'h0000_7e00);
        write_and_read(SS_ADDR_STOPWATCH, 32'h0000_0599);   // 5, 9, 9
        write_and_read(SS_ADDR_PROG, 32'h0000_013c);        // Down 2, prescale 60
        sw_run   = 1'b1;
        prog_run = 1'b1;
        clk_en   = 1'b1;
        wait_word_bit(SS_ADDR_PROG, 15, 400, 1'b0);
        wait_word_bit(SS_ADDR_STOPWATCH, 13, 1000, 1'b0);
        for (int i = 0; i < 400; i++) begin
            ss_bus_addr = i[0] ? SS_ADDR_PROG : SS_ADDR_STOPWATCH;
            next_cycle();
        end
        sw_run     = 1'b0;
        prog_run   = 1'b0;
        clk_en     = 1'b0;
        factor_ack = 1'b1;
        next_cycle();
        factor_ack = 1'b0;
        wait_irq(1'b0, 8);
        savestate_reset();

        // Counter 0x7f, next wrap drops the 32, 8 and 2 Hz levels
        write_and_read(SS_ADDR_CLOCK, 32'h0000_7f7f);
        ss_bus_addr = SS_ADDR_INTERRUPT;
        clk_en      = 1'b1;
        wait_irq(1'b1, 20);
        clk_en = 1'b0;
        wait_word_bit(SS_ADDR_INTERRUPT, 3, 4, 1'b0);
        k_in = 2'b11;
        next_cycle();
        k_in = 2'b00;
        wait_word_bit(SS_ADDR_INPUT, 1, 8, 1'b0);
        factor_ack = 1'b1;
        next_cycle();
        factor_ack = 1'b0;
        wait_irq(1'b0, 8);
        k_in = 2'b01;
        next_cycle();
        k_in       = 2'b00;
        factor_ack = 1'b1;  // Key edge in the same cycle as the ack
        next_cycle();
        factor_ack = 1'b0;
        check_bit("irq", 1'b1, irq);
        factor_ack = 1'b1;
        next_cycle();
        factor_ack = 1'b0;
        wait_irq(1'b0, 8);
        ss_bus_addr = 8'hff;
        run_cycles(3, 1'b0);

        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/clock_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_timer
    import ss_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clk_en,     // 32 kHz enable
    ss_bus_if.block     bus,
    output ss_word_t    rdata,
    output timer_bits_t timer_bits,
    output logic        tick_256
);

    logic [CLK_DIV_W-1:0] divider;
    logic [CLK_CNT_W-1:0] counter_256;
    logic                 timer_256_tick;

    logic ss_clear;
    logic ss_write;
    logic div_wrap;

    assign ss_clear = !rst_n || bus.load_defaults;
    assign ss_write = bus.wren && (bus.addr == SS_ADDR_CLOCK);
    assign div_wrap = clk_en && (divider == '1);    // 127 -> 0

    always_ff @(posedge clk) begin
        if (ss_clear) begin
            divider        <= '0;
            counter_256    <= '0;
            timer_256_tick <= 1'b0;
        end else if (ss_write) begin
            counter_256    <= bus.wdata[0 +: CLK_CNT_W];
            divider        <= bus.wdata[CLK_CNT_W +: CLK_DIV_W];
            timer_256_tick <= bus.wdata[CLK_CNT_W + CLK_DIV_W];
        end else begin
            if (clk_en) begin
                divider <= divider + 1'b1;  // Wraps on its own
            end
            if (div_wrap) begin
                counter_256 <= counter_256 + 1'b1;
            end
            // Only high for the cycle after the wrap
            timer_256_tick <= div_wrap;
        end
    end

    assign tick_256 = timer_256_tick;

    // Frequency levels straight off the 256 Hz counter
    assign timer_bits.timer_32hz = counter_256[TB_32HZ_BIT];
    assign timer_bits.timer_8hz  = counter_256[TB_8HZ_BIT];
    assign timer_bits.timer_2hz  = counter_256[TB_2HZ_BIT];
    assign timer_bits.timer_1hz  = counter_256[TB_1HZ_BIT];

    // {16'b0, timer_256_tick, divider, counter_256}
    assign rdata = ss_word_t'({timer_256_tick, divider, counter_256});

endmodule

`default_nettype wire

/* rtl/interrupt_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module interrupt_ctrl
    import ss_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   factor_ack,
    input  timer_bits_t            timer_bits,
    input  logic [KEY_W-1:0]       k_in,
    input  logic [SW_FACTOR_W-1:0] sw_factor,
    input  logic                   prog_factor,
    ss_bus_if.block                bus,
    output ss_word_t               clock_rdata,
    output ss_word_t               input_rdata,
    output logic                   irq
);

    timer_bits_t             prev_timer;    // Saved as part of address 5
    logic [TIMER_BITS_W-1:0] clock_factor;
    logic [KEY_W-1:0]        prev_k;
    logic [KEY_W-1:0]        factor_flags;  // Key input factors

    logic                    ss_clear;
    logic                    write_clock;
    logic                    write_input;
    logic [TIMER_BITS_W-1:0] timer_fall;
    logic [KEY_W-1:0]        key_fall;

    assign ss_clear    = !rst_n || bus.load_defaults;
    assign write_clock = bus.wren && (bus.addr == SS_ADDR_INTERRUPT);
    assign write_input = bus.wren && (bus.addr == SS_ADDR_INPUT);

    assign timer_fall = prev_timer & ~timer_bits;   // 1 -> 0 per level
    assign key_fall   = prev_k & ~k_in;

    always_ff @(posedge clk) begin
        if (ss_clear) begin
            prev_timer   <= '0;
            clock_factor <= '0;
        end else if (write_clock) begin
            clock_factor <= bus.wdata[0 +: TIMER_BITS_W];
            prev_timer   <= timer_bits_t'(bus.wdata[TIMER_BITS_W +: TIMER_BITS_W]);
        end else begin
            prev_timer   <= timer_bits;
            clock_factor <= (clock_factor & ~{TIMER_BITS_W{factor_ack}}) | timer_fall;
        end
    end

    // Key history is not part of any savestate word
    always_ff @(posedge clk) begin
        if (ss_clear) begin
            prev_k       <= '0;
            factor_flags <= '0;
        end else begin
            prev_k <= k_in;
            if (write_input) begin
                factor_flags <= bus.wdata[0 +: KEY_W];
            end else begin
                factor_flags <= (factor_flags & ~{KEY_W{factor_ack}}) | key_fall;
            end
        end
    end

    // Any latched factor, local or from the timers
    assign irq = |{clock_factor, factor_flags, sw_factor, prog_factor};

    assign clock_rdata = ss_word_t'({prev_timer, clock_factor});
    assign input_rdata = ss_word_t'(factor_flags);

endmodule

`default_nettype wire

/* rtl/prog_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module prog_timer
    import ss_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clk_en,       // 32 kHz enable
    input  logic                  prog_run,
    input  logic                  factor_ack,
    input  logic [PT_COUNT_W-1:0] prog_reload,
    ss_bus_if.block               bus,
    output ss_word_t              rdata,
    output logic                  prog_factor
);

    logic                     divider_8khz;   // Halves 32 kHz
    logic [PT_PRESCALE_W-1:0] counter_8khz;
    logic [PT_COUNT_W-1:0]    downcounter;
    logic                     factor_flag;

    logic ss_clear;
    logic ss_write;
    logic tick;
    logic step_8khz;
    logic step_down;
    logic underflow;

    assign ss_clear = !rst_n || bus.load_defaults;
    assign ss_write = bus.wren && (bus.addr == SS_ADDR_PROG);

    assign tick      = clk_en && prog_run;
    assign step_8khz = tick && divider_8khz;                  // Divider back to 0
    assign step_down = step_8khz && (counter_8khz == '1);     // 256 Hz step
    assign underflow = step_down && (downcounter == PT_COUNT_W'(1));

    always_ff @(posedge clk) begin
        if (ss_clear) begin
            divider_8khz <= 1'b0;
            counter_8khz <= '0;
            downcounter  <= '0;
            factor_flag  <= 1'b0;
        end else if (ss_write) begin
            counter_8khz <= bus.wdata[0 +: PT_PRESCALE_W];
            divider_8khz <= bus.wdata[PT_PRESCALE_W];
            downcounter  <= bus.wdata[PT_PRESCALE_W + 1 +: PT_COUNT_W];
            factor_flag  <= bus.wdata[PT_PRESCALE_W + 1 + PT_COUNT_W];
        end else begin
            if (tick) begin
                divider_8khz <= !divider_8khz;
            end
            if (step_8khz) begin
                counter_8khz <= counter_8khz + 1'b1;
            end

            if (step_down) begin
                // Reload on 1 -> 0, and also out of a restored zero
                if (downcounter <= PT_COUNT_W'(1)) begin
                    downcounter <= prog_reload;
                end else begin
                    downcounter <= downcounter - 1'b1;
                end
            end

            if (underflow) begin
                factor_flag <= 1'b1;    // Set beats ack
            end else if (factor_ack) begin
                factor_flag <= 1'b0;
            end
        end
    end

    assign prog_factor = factor_flag;

    // {16'b0, factor_flag, downcounter, divider_8khz, counter_8khz}
    assign rdata = ss_word_t'({factor_flag, downcounter, divider_8khz, counter_8khz});

endmodule

`default_nettype wire

/* rtl/ss_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Savestate bus, one driver and several state blocks
interface ss_bus_if
    import ss_pkg::*;
();

    ss_addr_t addr;             // Word select
    ss_word_t wdata;            // Word to restore
    logic     wren;             // Single-cycle write strobe
    logic     load_defaults;    // Savestate reset, held as a level

    modport hub (
        output addr,
        output wdata,
        output wren,
        output load_defaults
    );

    // Blocks only listen, state comes back on their own rdata ports
    modport block (
        input addr,
        input wdata,
        input wren,
        input load_defaults
    );

endinterface

`default_nettype wire

/* rtl/ss_pkg.sv */
`default_nettype none

package ss_pkg;

    localparam int SS_WORD_W = 32;
    localparam int SS_ADDR_W = 8;

    typedef logic [SS_WORD_W-1:0] ss_word_t;
    typedef logic [SS_ADDR_W-1:0] ss_addr_t;

    // Savestate addresses, 0 and 1 belong to the CPU core
    localparam ss_addr_t SS_ADDR_CLOCK     = 8'd2;
    localparam ss_addr_t SS_ADDR_STOPWATCH = 8'd3;
    localparam ss_addr_t SS_ADDR_PROG      = 8'd4;
    localparam ss_addr_t SS_ADDR_INTERRUPT = 8'd5;
    localparam ss_addr_t SS_ADDR_INPUT     = 8'd6;

    // Clock timer fields
    localparam int CLK_CNT_W = 8;   // counter_256
    localparam int CLK_DIV_W = 7;   // 32 kHz divider

    // Positions of the timer levels inside counter_256
    localparam int TB_32HZ_BIT = 2;
    localparam int TB_8HZ_BIT  = 4;
    localparam int TB_2HZ_BIT  = 6;
    localparam int TB_1HZ_BIT  = 7;

    // Stopwatch fields
    localparam int SW_DIGIT_W  = 4;
    localparam int SW_FACTOR_W = 2;
    localparam logic [SW_DIGIT_W-1:0] SW_DIGIT_MAX = 4'd9;

    // Prog timer fields
    localparam int PT_PRESCALE_W = 6;   // counter_8khz
    localparam int PT_COUNT_W    = 8;   // downcounter and reload value

    // Interrupt fields
    localparam int TIMER_BITS_W = 4;
    localparam int KEY_W        = 2;

    typedef struct packed {
        logic timer_32hz;   // Bit 3, matches clock_factor bit 3
        logic timer_8hz;
        logic timer_2hz;
        logic timer_1hz;
    } timer_bits_t;

endpackage

`default_nettype wire

/* rtl/stopwatch.sv */
`timescale 1ns/1ps
`default_nettype none

module stopwatch
    import ss_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   tick_256,
    input  logic                   sw_run,
    input  logic                   factor_ack,
    ss_bus_if.block                bus,
    output ss_word_t               rdata,
    output logic [SW_FACTOR_W-1:0] sw_factor
);

    logic [SW_DIGIT_W-1:0]  counter_100hz;  // Hundredths stage
    logic [SW_DIGIT_W-1:0]  counter_swl;    // Low BCD digit
    logic [SW_DIGIT_W-1:0]  counter_swh;    // High BCD digit
    logic [SW_FACTOR_W-1:0] factor_flags;

    logic ss_clear;
    logic ss_write;
    logic step;
    logic wrap_100hz;
    logic wrap_swl;
    logic wrap_swh;

    assign ss_clear = !rst_n || bus.load_defaults;
    assign ss_write = bus.wren && (bus.addr == SS_ADDR_STOPWATCH);

    // Carry chain, >= so an out of range restore still rolls over
    assign step       = tick_256 && sw_run;
    assign wrap_100hz = step && (counter_100hz >= SW_DIGIT_MAX);
    assign wrap_swl   = wrap_100hz && (counter_swl >= SW_DIGIT_MAX);
    assign wrap_swh   = wrap_swl && (counter_swh >= SW_DIGIT_MAX);

    always_ff @(posedge clk) begin
        if (ss_clear) begin
            counter_100hz <= '0;
            counter_swl   <= '0;
            counter_swh   <= '0;
            factor_flags  <= '0;
        end else if (ss_write) begin
            counter_swl   <= bus.wdata[0 +: SW_DIGIT_W];
            counter_swh   <= bus.wdata[SW_DIGIT_W +: SW_DIGIT_W];
            counter_100hz <= bus.wdata[2*SW_DIGIT_W +: SW_DIGIT_W];
            factor_flags  <= bus.wdata[3*SW_DIGIT_W +: SW_FACTOR_W];
        end else begin
            if (wrap_100hz) begin
                counter_100hz <= '0;
            end else if (step) begin
                counter_100hz <= counter_100hz + 1'b1;
            end

            if (wrap_swl) begin
                counter_swl <= '0;
            end else if (wrap_100hz) begin
                counter_swl <= counter_swl + 1'b1;
            end

            if (wrap_swh) begin
                counter_swh <= '0;
            end else if (wrap_swl) begin
                counter_swh <= counter_swh + 1'b1;
            end

            // New rollover wins over an ack in the same cycle
            factor_flags <= (factor_flags & ~{SW_FACTOR_W{factor_ack}})
                          | {wrap_swh, wrap_swl};
        end
    end

    assign sw_factor = factor_flags;

    // {18'b0, factor_flags, counter_100hz, counter_swh, counter_swl}
    assign rdata = ss_word_t'({factor_flags, counter_100hz, counter_swh, counter_swl});

endmodule

`default_nettype wire

/* rtl/timers_top.sv */
`timescale 1ns/1ps
`default_nettype none

module timers_top
    import ss_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clk_en,
    input  logic                  sw_run,
    input  logic                  prog_run,
    input  logic                  factor_ack,
    input  logic [PT_COUNT_W-1:0] prog_reload,
    input  logic [KEY_W-1:0]      k_in,
    input  ss_addr_t              ss_bus_addr,
    input  ss_word_t              ss_bus_in,
    input  logic                  ss_bus_wren,
    input  logic                  ss_bus_reset_n,
    output ss_word_t              ss_bus_out,
    output logic                  irq
);

    ss_word_t                clock_rdata;
    ss_word_t                sw_rdata;
    ss_word_t                prog_rdata;
    ss_word_t                int_clock_rdata;
    ss_word_t                int_input_rdata;
    timer_bits_t             timer_bits;
    logic                    tick_256;
    logic [SW_FACTOR_W-1:0]  sw_factor;
    logic                    prog_factor;

    ss_bus_if bus ();

    assign bus.addr          = ss_bus_addr;
    assign bus.wdata         = ss_bus_in;
    assign bus.wren          = ss_bus_wren;
    assign bus.load_defaults = !ss_bus_reset_n;

    clock_timer clock (
        .clk        (clk),
        .rst_n      (rst_n),
        .clk_en     (clk_en),
        .bus        (bus.block),
        .rdata      (clock_rdata),
        .timer_bits (timer_bits),
        .tick_256   (tick_256)
    );

    stopwatch stopwatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick_256   (tick_256),
        .sw_run     (sw_run),
        .factor_ack (factor_ack),
        .bus        (bus.block),
        .rdata      (sw_rdata),
        .sw_factor  (sw_factor)
    );

    prog_timer prog_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_en      (clk_en),
        .prog_run    (prog_run),
        .factor_ack  (factor_ack),
        .prog_reload (prog_reload),
        .bus         (bus.block),
        .rdata       (prog_rdata),
        .prog_factor (prog_factor)
    );

    interrupt_ctrl interrupt (
        .clk         (clk),
        .rst_n       (rst_n),
        .factor_ack  (factor_ack),
        .timer_bits  (timer_bits),
        .k_in        (k_in),
        .sw_factor   (sw_factor),
        .prog_factor (prog_factor),
        .bus         (bus.block),
        .clock_rdata (int_clock_rdata),
        .input_rdata (int_input_rdata),
        .irq         (irq)
    );

    // Read word for the address seen at this edge, unused addresses give zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ss_bus_out <= '0;
        end else begin
            case (ss_bus_addr)
                SS_ADDR_CLOCK:     ss_bus_out <= clock_rdata;
                SS_ADDR_STOPWATCH: ss_bus_out <= sw_rdata;
                SS_ADDR_PROG:      ss_bus_out <= prog_rdata;
                SS_ADDR_INTERRUPT: ss_bus_out <= int_clock_rdata;
                SS_ADDR_INPUT:     ss_bus_out <= int_input_rdata;
                default:           ss_bus_out <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* timers_top.f */
rtl/ss_pkg.sv
rtl/ss_bus_if.sv
rtl/clock_timer.sv
rtl/stopwatch.sv
rtl/prog_timer.sv
rtl/interrupt_ctrl.sv
rtl/timers_top.sv
bench/timers_asserts.sv
bench/timers_tb.sv
